// ==== sim.f ====
+incdir+rtl
rtl/etx_pkg.sv
rtl/etx_cfg.sv
rtl/etx_queue.sv
rtl/etx_arbiter.sv
rtl/etx_remap.sv
rtl/etx_framer.sv
rtl/etx.sv
testbench/etx_tb.sv

// ==== Bender.yml ====
package:
  name: etx

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/etx_pkg.sv
      - rtl/etx_cfg.sv
      - rtl/etx_queue.sv
      - rtl/etx_arbiter.sv
      - rtl/etx_remap.sv
      - rtl/etx_framer.sv
      - rtl/etx.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/etx_tb.sv

// ==== testbench/etx_tb.sv ====
`timescale 1ns/10ps
`include "etx_consts.svh"

module etx_tb
   import etx_pkg::*;
();

   localparam int NUM_PKT = 96;  // Sum of all traffic phases
   localparam int RST_CYC = 16;

   logic                  mi_clk, rst_n, mi_en, mi_we, link_credit;
   logic [`ETX_MI_AW-1:0] mi_addr;
   logic [31:0]           mi_din, mi_cfg_dout, mi_remap_dout;
   logic [2:0]            cl_valid;   // Index is the opcode for wr, rd, rr
   logic [2:0]            cl_credit;
   etx_packet_t           cl_packet [3];
   etx_link_t             link_out;

   integer      seed = 32'h67cf1b70;
   int          errors, owed, granted, starts, rx_n;
   int          cl_cred [3];                  // Client credits in hand
   int          pushed [3];
   int          returned [3];
   etx_packet_t exp_q [3][$];                 // Expected link packets per opcode
   logic [7:0]  rx [13];                      // Bytes of the frame on the lane
   logic [31:0] ctrl_s;                       // Shadow control register
   logic [11:0] tbl_s [`ETX_REMAP_ENTRIES];   // Shadow remap table
   bit          hold, no_frame;

   etx uut (
      .mi_clk, .rst_n, .mi_en, .mi_we, .mi_addr, .mi_din, .mi_cfg_dout, .mi_remap_dout,
      .wr_valid (cl_valid[0]), .wr_packet (cl_packet[0]), .wr_credit (cl_credit[0]),
      .rd_valid (cl_valid[1]), .rd_packet (cl_packet[1]), .rd_credit (cl_credit[1]),
      .rr_valid (cl_valid[2]), .rr_packet (cl_packet[2]), .rr_credit (cl_credit[2]),
      .link_out, .link_credit);

   always #2 mi_clk = ~mi_clk;  // 4 ns period

   // Packet as the link should carry it
   function automatic etx_packet_t xlat(input etx_packet_t p);
      etx_packet_t q;
      q = p;
      if (ctrl_s[1])
         q.dst_addr[31:20] = tbl_s[p.dst_addr[31:28]];
      if (ctrl_s[2])
         q.ctrlmode = ctrl_s[7:4];
      if (p.op != op_read_req)
         q.src_addr = 32'd0;  // Not sent for 9 byte packets
      return q;
   endfunction

   task automatic check_packet(input string name, input etx_packet_t got, input etx_packet_t exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic log_error(input string msg);
      $display("error at %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic finish_run();
      $display("etx_tb: %0d errors, %0d frames started", errors, starts);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   endtask

   task automatic reg_write(input int addr, input logic [31:0] data);
      @(negedge mi_clk);
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = addr;
      mi_din  = data;
      @(negedge mi_clk);
      mi_en = 1'b0;
      mi_we = 1'b0;
      if (addr == `ETX_REG_CTRL)
         ctrl_s = data & 32'h000000f7;  // Bit 3 and above 7 unused
      else
         tbl_s[addr - `ETX_REG_REMAP_BASE] = data[11:0];
   endtask

   task automatic reg_check(input int addr);
      logic [31:0] exp_cfg, exp_map;
      exp_cfg = 32'd0;
      exp_map = 32'd0;
      if (addr == `ETX_REG_CTRL)
         exp_cfg = ctrl_s;
      else
         exp_map = {20'd0, tbl_s[addr - `ETX_REG_REMAP_BASE]};
      @(negedge mi_clk);
      mi_en   = 1'b1;
      mi_we   = 1'b0;
      mi_addr = addr;
      @(negedge mi_clk);
      mi_en = 1'b0;                 // Read data now registered
      check_word("mi_cfg_dout", mi_cfg_dout, exp_cfg);
      check_word("mi_remap_dout", mi_remap_dout, exp_map);
   endtask

   task automatic push_random();
      int          ch;
      etx_packet_t p;
      @(negedge mi_clk);
      ch = $unsigned($random(seed)) % 3;
      while (cl_cred[ch] == 0)
      begin
         @(negedge mi_clk);
         ch = $unsigned($random(seed)) % 3;
      end
      p.op       = etx_op_e'(ch);
      p.ctrlmode = $random(seed);
      p.dst_addr = $random(seed);
      p.data     = $random(seed);
      p.src_addr = $random(seed);
      cl_valid[ch]  = 1'b1;
      cl_packet[ch] = p;
      cl_cred[ch]--;
      pushed[ch]++;
      exp_q[ch].push_back(xlat(p));
      @(negedge mi_clk);
      cl_valid = 3'b000;
   endtask

   task automatic traffic(input int n);
      repeat (n)
      begin
         push_random();
         repeat ($unsigned($random(seed)) % 3) @(negedge mi_clk);  // Idle gap
      end
   endtask

   task automatic drain();
      while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0 || owed != 0)
         @(negedge mi_clk);
   endtask

   task automatic take_frame();
      etx_packet_t got, exp;
      int          op;
      op = rx[0][7:6];
      if (op > 2)
         log_error("frame header carries an unknown opcode");
      else if (rx_n != ((op == op_read_req) ? 13 : 9))
         log_error("frame length does not fit its opcode");
      else if (exp_q[op].size() == 0)
         log_error("frame received with no packet outstanding");
      else
      begin
         got          = '0;
         got.op       = etx_op_e'(op);
         got.ctrlmode = rx[0][5:2];
         got.dst_addr = {rx[1], rx[2], rx[3], rx[4]};
         got.data     = {rx[5], rx[6], rx[7], rx[8]};
         if (op == op_read_req)
            got.src_addr = {rx[9], rx[10], rx[11], rx[12]};
         exp = exp_q[op].pop_front();
         check_packet("link packet", got, exp);
         check_word("header pad bits", {30'd0, rx[0][1:0]}, 32'd0);
      end
   endtask

   // Client credit returns
   always @(posedge mi_clk)
   begin
      for (int ch = 0; ch < 3; ch++)
         if (rst_n && cl_credit[ch])
         begin
            returned[ch]++;
            cl_cred[ch]++;
            if (returned[ch] > pushed[ch])
               log_error("client credit returned without a push");
         end
   end

   // Lane receiver
   always @(posedge mi_clk)
   begin
      if (rst_n && link_out.frame)
      begin
         if (rx_n == 0)
         begin
            starts++;
            if (no_frame)
               log_error("frame sent while tx_enable was clear");
            if (starts > `ETX_LINK_CREDITS + granted)
               log_error("frame started without a link credit");
         end
         if (rx_n < 13)
            rx[rx_n] = link_out.data;
         rx_n++;
      end
      else if (rst_n && rx_n > 0)
      begin
         take_frame();
         rx_n = 0;
         owed++;       // Far end frees this slot later
      end
   end

   // Far end returns slots at random unless held
   always @(negedge mi_clk)
   begin
      link_credit = 1'b0;
      if (rst_n && !hold && owed > 0 && ($random(seed) & 3) != 0)
      begin
         link_credit = 1'b1;
         owed--;
         granted++;
      end
   end

   initial
   begin
      #((RST_CYC + 200 * NUM_PKT) * 4);
      log_error("watchdog expired before traffic drained");
      finish_run();
   end

   initial
   begin
      mi_clk      = 1'b0;
      rst_n       = 1'b0;
      mi_en       = 1'b0;
      mi_we       = 1'b0;
      mi_addr     = '0;
      mi_din      = 32'd0;
      link_credit = 1'b0;
      cl_valid    = 3'b000;
      ctrl_s      = 32'd0;
      foreach (cl_packet[i])
         cl_packet[i] = '0;
      foreach (cl_cred[i])
         cl_cred[i] = `ETX_QUEUE_DEPTH;
      foreach (tbl_s[i])
         tbl_s[i] = 12'd0;
      repeat (RST_CYC) @(posedge mi_clk);
      @(negedge mi_clk);
      rst_n = 1'b1;
      repeat (20) @(negedge mi_clk);             // Idle while monitors watch for frames
      reg_check(`ETX_REG_CTRL);
      reg_check(`ETX_REG_REMAP_BASE + 5);
      reg_write(`ETX_REG_CTRL, 32'h000000a6);    // All bits but tx_enable
      reg_check(`ETX_REG_CTRL);
      for (int i = 0; i < `ETX_REMAP_ENTRIES; i++)
         reg_write(`ETX_REG_REMAP_BASE + i, $random(seed));
      for (int i = 0; i < `ETX_REMAP_ENTRIES; i++)
         reg_check(`ETX_REG_REMAP_BASE + i);
      reg_write(`ETX_REG_CTRL, 32'h00000001);    // Plain traffic
      traffic(40);
      drain();
      reg_write(`ETX_REG_CTRL, 32'h00000057);    // Remap and override mode 5
      traffic(40);
      drain();
      hold = 1'b1;                               // Far end withholds credits
      traffic(10);
      repeat (100) @(negedge mi_clk);
      hold = 1'b0;
      drain();
      reg_write(`ETX_REG_CTRL, 32'h00000056);    // Transmit off
      no_frame = 1'b1;
      traffic(6);
      repeat (60) @(negedge mi_clk);
      no_frame = 1'b0;
      reg_write(`ETX_REG_CTRL, 32'h00000057);
      drain();
      for (int ch = 0; ch < 3; ch++)
      begin
         check_word("client credits returned", returned[ch], pushed[ch]);
         for (int k = 0; k < exp_q[ch].size(); k++)
            log_error($sformatf("packet still outstanding on channel %0d", ch));
      end
      finish_run();
   end

endmodule

// ==== rtl/etx.sv ====
`timescale 1ns/10ps
`include "etx_consts.svh"

module etx
   import etx_pkg::*;
(
   input  logic                  mi_clk,
   input  logic                  rst_n,
   input  logic                  mi_en,
   input  logic                  mi_we,
   input  logic [`ETX_MI_AW-1:0] mi_addr,
   input  logic [31:0]           mi_din,
   output logic [31:0]           mi_cfg_dout,
   output logic [31:0]           mi_remap_dout,
   input  logic                  wr_valid,
   input  etx_packet_t           wr_packet,
   output logic                  wr_credit,
   input  logic                  rd_valid,
   input  etx_packet_t           rd_packet,
   output logic                  rd_credit,
   input  logic                  rr_valid,
   input  etx_packet_t           rr_packet,
   output logic                  rr_credit,
   output etx_link_t             link_out,
   input  logic                  link_credit
);

   logic        tx_enable, remap_enable, ctrl_override;
   logic [3:0]  ctrlmode;
   logic        wr_head_valid, rd_head_valid, rr_head_valid;
   etx_packet_t wr_head_packet, rd_head_packet, rr_head_packet;
   logic        wr_pop, rd_pop, rr_pop;
   logic        arb_valid, arb_ready;  // Arbiter to remap
   etx_packet_t arb_packet;
   logic        map_valid, map_ready;  // Remap to framer
   etx_packet_t map_packet;

   etx_cfg etx_cfg (
      .mi_clk, .rst_n, .mi_en, .mi_we, .mi_addr, .mi_din,
      .mi_dout       (mi_cfg_dout),
      .tx_enable, .remap_enable, .ctrl_override, .ctrlmode);

   etx_queue wr_queue (
      .mi_clk, .rst_n,
      .push (wr_valid), .push_packet (wr_packet), .pop (wr_pop),
      .head_valid (wr_head_valid), .head_packet (wr_head_packet), .credit (wr_credit));

   etx_queue rd_queue (
      .mi_clk, .rst_n,
      .push (rd_valid), .push_packet (rd_packet), .pop (rd_pop),
      .head_valid (rd_head_valid), .head_packet (rd_head_packet), .credit (rd_credit));

   etx_queue rr_queue (
      .mi_clk, .rst_n,
      .push (rr_valid), .push_packet (rr_packet), .pop (rr_pop),
      .head_valid (rr_head_valid), .head_packet (rr_head_packet), .credit (rr_credit));

   etx_arbiter etx_arbiter (
      .mi_clk, .rst_n,
      .wr_head_valid, .wr_head_packet, .rd_head_valid, .rd_head_packet,
      .rr_head_valid, .rr_head_packet,
      .out_ready (arb_ready),
      .wr_pop, .rd_pop, .rr_pop,
      .out_valid (arb_valid), .out_packet (arb_packet));

   etx_remap etx_remap (
      .mi_clk, .rst_n, .mi_en, .mi_we, .mi_addr, .mi_din,
      .mi_dout   (mi_remap_dout),
      .remap_enable, .ctrl_override, .ctrlmode,
      .in_valid  (arb_valid), .in_packet (arb_packet), .in_ready (arb_ready),
      .out_ready (map_ready), .out_valid (map_valid), .out_packet (map_packet));

   etx_framer etx_framer (
      .mi_clk, .rst_n, .tx_enable, .link_credit,
      .in_valid (map_valid), .in_packet (map_packet), .in_ready (map_ready),
      .link_out);

endmodule

// ==== rtl/etx_framer.sv ====
`timescale 1ns/10ps
`include "etx_consts.svh"

module etx_framer
   import etx_pkg::*;
(
   input  logic        mi_clk,
   input  logic        rst_n,
   input  logic        tx_enable,
   input  logic        link_credit,
   input  logic        in_valid,
   input  etx_packet_t in_packet,
   output logic        in_ready,
   output etx_link_t   link_out
);

   localparam int CRD_W = $clog2(`ETX_LINK_CREDITS + 1);

   etx_frame_state_e state;
   etx_packet_t      buf_packet;  // Packet sent or waiting
   logic             buf_valid;
   logic [3:0]       byte_cnt;    // Body byte index
   logic [3:0]       body_last;   // Last body index by opcode
   logic [CRD_W-1:0] credit_cnt;  // Link credits in hand
   logic             start;       // Packet takes a credit
   logic             done;        // Last body byte on the lane
   logic [95:0]      body;

   assign body      = {buf_packet.dst_addr, buf_packet.data, buf_packet.src_addr};
   assign body_last = (buf_packet.op == op_read_req) ? 4'd11 : 4'd7;  // 13 or 9 bytes
   assign start     = (state == st_idle) && buf_valid && tx_enable && (credit_cnt != '0);
   assign done      = (state == st_body) && (byte_cnt == body_last);
   assign in_ready  = !buf_valid || done;  // Refill during last byte

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
      begin
         state    <= st_idle;
         byte_cnt <= 4'd0;
      end
      else
      begin
         case (state)
            st_idle:
               if (start)
                  state <= st_header;
            st_header:
            begin
               state    <= st_body;
               byte_cnt <= 4'd0;
            end
            st_body:
               if (done)
                  state <= st_idle;  // Frame drops for at least a cycle
               else
                  byte_cnt <= byte_cnt + 1'b1;
            default:
               state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
         buf_valid <= 1'b0;
      else if (in_valid && in_ready)
         buf_valid <= 1'b1;
      else if (done)
         buf_valid <= 1'b0;
   end

   always_ff @(posedge mi_clk)
   begin
      if (in_valid && in_ready)
         buf_packet <= in_packet;
   end

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
         credit_cnt <= CRD_W'(`ETX_LINK_CREDITS);
      else
         case ({link_credit, start})
            2'b10:   credit_cnt <= credit_cnt + 1'b1;
            2'b01:   credit_cnt <= credit_cnt - 1'b1;
            default: credit_cnt <= credit_cnt;
         endcase
   end

   always_comb
   begin
      link_out.frame = (state != st_idle);
      link_out.data  = 8'd0;
      if (state == st_header)
         link_out.data = {buf_packet.op, buf_packet.ctrlmode, 2'b00};
      else if (state == st_body)
         link_out.data = body[95 - 8*byte_cnt -: 8];  // MSB first
   end

   // Far end returns no more credits than packets sent
   assert property (@(posedge mi_clk) disable iff (!rst_n)
                    credit_cnt <= CRD_W'(`ETX_LINK_CREDITS))
      else $error("etx_framer: link credit overflow");

endmodule

// ==== rtl/etx_remap.sv ====
`timescale 1ns/10ps
`include "etx_consts.svh"

module etx_remap
   import etx_pkg::*;
(
   input  logic                  mi_clk,
   input  logic                  rst_n,
   input  logic                  mi_en,
   input  logic                  mi_we,
   input  logic [`ETX_MI_AW-1:0] mi_addr,
   input  logic [31:0]           mi_din,
   output logic [31:0]           mi_dout,
   input  logic                  remap_enable,
   input  logic                  ctrl_override,
   input  logic [3:0]            ctrlmode,
   input  logic                  in_valid,
   input  etx_packet_t           in_packet,
   output logic                  in_ready,
   input  logic                  out_ready,
   output logic                  out_valid,
   output etx_packet_t           out_packet
);

   localparam int IDX_W = $clog2(`ETX_REMAP_ENTRIES);

   logic [11:0]      remap_table [`ETX_REMAP_ENTRIES];  // New dst_addr[31:20]
   logic             tbl_hit;      // Access inside table window
   logic [IDX_W-1:0] mi_idx;
   logic [IDX_W-1:0] pkt_idx;      // From dst_addr[31:28]
   etx_packet_t      xlat_packet;  // Translated input

   assign tbl_hit = mi_en && (mi_addr >= `ETX_REG_REMAP_BASE)
                    && (mi_addr < `ETX_REG_REMAP_BASE + `ETX_REMAP_ENTRIES);
   assign mi_idx   = mi_addr[IDX_W-1:0];  // Window aligned to its size
   assign pkt_idx  = in_packet.dst_addr[31 -: IDX_W];
   assign in_ready = !out_valid || out_ready;  // Stall while framer is busy

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < `ETX_REMAP_ENTRIES; i++)
            remap_table[i] <= 12'd0;
      end
      else if (tbl_hit && mi_we)
         remap_table[mi_idx] <= mi_din[11:0];
   end

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
         mi_dout <= 32'd0;
      else if (tbl_hit && !mi_we)
         mi_dout <= {20'd0, remap_table[mi_idx]};
      else
         mi_dout <= 32'd0;  // Control register reads come from cfg
   end

   always_comb
   begin
      xlat_packet = in_packet;
      if (remap_enable)
         xlat_packet.dst_addr[31:20] = remap_table[pkt_idx];
      if (ctrl_override)
         xlat_packet.ctrlmode = ctrlmode;
   end

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
         out_valid <= 1'b0;
      else if (in_ready)
         out_valid <= in_valid;
   end

   always_ff @(posedge mi_clk)
   begin
      if (in_valid && in_ready)
         out_packet <= xlat_packet;
   end

endmodule

// ==== rtl/etx_arbiter.sv ====
`timescale 1ns/10ps

module etx_arbiter
   import etx_pkg::*;
(
   input  logic        mi_clk,
   input  logic        rst_n,
   input  logic        wr_head_valid,
   input  etx_packet_t wr_head_packet,
   input  logic        rd_head_valid,
   input  etx_packet_t rd_head_packet,
   input  logic        rr_head_valid,
   input  etx_packet_t rr_head_packet,
   input  logic        out_ready,
   output logic        wr_pop,
   output logic        rd_pop,
   output logic        rr_pop,
   output logic        out_valid,
   output etx_packet_t out_packet
);

   logic        load;        // Output stage empty or drained this cycle
   logic        any_pop;
   etx_packet_t win_packet;  // Head of winning queue

   assign load    = !out_valid || out_ready;
   assign rr_pop  = load && rr_head_valid;                   // Responses first
   assign wr_pop  = load && wr_head_valid && !rr_head_valid;  // Then writes
   assign rd_pop  = load && rd_head_valid && !rr_head_valid && !wr_head_valid;
   assign any_pop = rr_pop || wr_pop || rd_pop;

   always_comb
   begin
      win_packet = rd_head_packet;
      if (rr_head_valid)
         win_packet = rr_head_packet;
      else if (wr_head_valid)
         win_packet = wr_head_packet;
   end

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
         out_valid <= 1'b0;
      else if (load)
         out_valid <= any_pop;  // Empties when nothing waits
   end

   always_ff @(posedge mi_clk)
   begin
      if (any_pop)
         out_packet <= win_packet;
   end

   assert property (@(posedge mi_clk) disable iff (!rst_n) $onehot0({rr_pop, wr_pop, rd_pop}))
      else $error("etx_arbiter: more than one pop");

endmodule

// ==== rtl/etx_queue.sv ====
`timescale 1ns/10ps
`include "etx_consts.svh"

module etx_queue
   import etx_pkg::*;
(
   input  logic        mi_clk,
   input  logic        rst_n,
   input  logic        push,
   input  etx_packet_t push_packet,
   input  logic        pop,
   output logic        head_valid,
   output etx_packet_t head_packet,
   output logic        credit
);

   localparam int PTR_W = $clog2(`ETX_QUEUE_DEPTH);
   localparam int CNT_W = $clog2(`ETX_QUEUE_DEPTH + 1);

   etx_packet_t      mem [`ETX_QUEUE_DEPTH];  // Packet storage
   logic [PTR_W-1:0] wr_ptr;                  // Next free slot
   logic [PTR_W-1:0] rd_ptr;                  // Oldest entry
   logic [CNT_W-1:0] count;                   // Occupancy
   logic             full;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(`ETX_QUEUE_DEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign full        = (count == CNT_W'(`ETX_QUEUE_DEPTH));
   assign head_valid  = (count != '0);
   assign head_packet = mem[rd_ptr];         // Head seen the cycle after push
   assign credit      = pop && head_valid;   // One credit back per pop

   always_ff @(posedge mi_clk)
   begin
      if (push)
         mem[wr_ptr] <= push_packet;
   end

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop)
            rd_ptr <= next_ptr(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Both or neither
         endcase
      end
   end

   // Client never pushes without a credit, so full means a lost credit
   assert property (@(posedge mi_clk) disable iff (!rst_n) push |-> !full)
      else $error("etx_queue: push while full");

   // Arbiter only pops a valid head
   assert property (@(posedge mi_clk) disable iff (!rst_n) pop |-> head_valid)
      else $error("etx_queue: pop while empty");

endmodule

// ==== rtl/etx_cfg.sv ====
`timescale 1ns/10ps
`include "etx_consts.svh"

module etx_cfg (
   input  logic                  mi_clk,
   input  logic                  rst_n,
   input  logic                  mi_en,
   input  logic                  mi_we,
   input  logic [`ETX_MI_AW-1:0] mi_addr,
   input  logic [31:0]           mi_din,
   output logic [31:0]           mi_dout,
   output logic                  tx_enable,
   output logic                  remap_enable,
   output logic                  ctrl_override,
   output logic [3:0]            ctrlmode
);

   logic        ctrl_hit;   // Access to control register
   logic [31:0] ctrl_word;  // Control register as read back

   assign ctrl_hit  = mi_en && (mi_addr == `ETX_REG_CTRL);
   assign ctrl_word = {24'd0, ctrlmode, 1'b0, ctrl_override, remap_enable, tx_enable};

   // Control bits, written on the next edge
   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
      begin
         tx_enable     <= 1'b0;
         remap_enable  <= 1'b0;
         ctrl_override <= 1'b0;
         ctrlmode      <= 4'd0;
      end
      else if (ctrl_hit && mi_we)
      begin
         tx_enable     <= mi_din[0];    // Framer may start packets
         remap_enable  <= mi_din[1];    // Address translation on
         ctrl_override <= mi_din[2];    // Replace packet ctrlmode
         ctrlmode      <= mi_din[7:4];  // Override value
      end
   end

   // Read data one cycle after the request
   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
         mi_dout <= 32'd0;
      else if (ctrl_hit && !mi_we)
         mi_dout <= ctrl_word;
      else
         mi_dout <= 32'd0;  // Other addresses belong to remap
   end

endmodule

// ==== rtl/etx_pkg.sv ====
package etx_pkg;

   // Packet kind, also sent in header bits 7:6
   typedef enum logic [1:0] {
      op_write     = 2'd0,   // Posted write
      op_read_req  = 2'd1,   // Read request with return address
      op_read_resp = 2'd2    // Read response
   } etx_op_e;

   // One client packet, 102 bits
   typedef struct packed {
      etx_op_e     op;        // Packet kind
      logic [3:0]  ctrlmode;  // Control mode for far end
      logic [31:0] dst_addr;  // Destination address
      logic [31:0] data;      // Write or response data
      logic [31:0] src_addr;  // Return address for reads
   } etx_packet_t;

   // Link byte lane
   typedef struct packed {
      logic       frame;  // High on every byte of a packet
      logic [7:0] data;   // Byte, MSB first order
   } etx_link_t;

   // Framer states
   typedef enum logic [1:0] {
      st_idle   = 2'd0,  // Frame low, waiting for packet and credit
      st_header = 2'd1,  // Op and ctrlmode byte
      st_body   = 2'd2   // Address, data and return address bytes
   } etx_frame_state_e;

endpackage

// ==== rtl/etx_consts.svh ====
`ifndef ETX_CONSTS_SVH
`define ETX_CONSTS_SVH

// Entries per client queue, also the client credits after reset
`define ETX_QUEUE_DEPTH 4

// Link credits held after reset and the most the far end may return
`define ETX_LINK_CREDITS 2

// Remap entries, indexed by dst_addr[31:28]
`define ETX_REMAP_ENTRIES 16

// Register port address width
`define ETX_MI_AW 8

// Control register address
`define ETX_REG_CTRL 0

// First remap entry; entries occupy 16 to 31
`define ETX_REG_REMAP_BASE 16

`endif
